// ==== decode_pipe_reg.sv ====
////////////////////////////////////////////////////////////////////////////
// Decode pipeline register for pc, instruction, bubble and exceptions.
// Priority is reset, flush, ex_stall hold, then bubble insertion when
// decode itself stalls on a load-use hazard.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module decode_pipe_reg (
  input  logic                          clk,
  input  logic                          rstn,
  input  decode_pkg::fetch_t            fetch,
  input  logic [decode_pkg::EXC_W-1:0]  dec_exc,
  input  logic                          ex_stall,
  input  logic                          id_stall,
  input  logic                          flush,
  input  logic [decode_pkg::XLEN-1:0]   flush_pc,
  output decode_pkg::decode_t           id,
  output logic                          bubble_r
);

  logic [decode_pkg::XLEN-1:0]  pc_r;
  logic [decode_pkg::ILEN-1:0]  instr_r;
  logic [decode_pkg::EXC_W-1:0] exc_r;
  logic [decode_pkg::EXC_W-1:0] exc_next;

  // Fetch exceptions pass, decode causes come from the checker
  always_comb begin
    exc_next = fetch.exception;
    exc_next[decode_pkg::CAUSE_ILLEGAL_INSTRUCTION] =
      dec_exc[decode_pkg::CAUSE_ILLEGAL_INSTRUCTION];
    exc_next[decode_pkg::CAUSE_BREAKPOINT]  = dec_exc[decode_pkg::CAUSE_BREAKPOINT];
    exc_next[decode_pkg::CAUSE_UMODE_ECALL] = dec_exc[decode_pkg::CAUSE_UMODE_ECALL];
    exc_next[decode_pkg::CAUSE_SMODE_ECALL] = dec_exc[decode_pkg::CAUSE_SMODE_ECALL];
    exc_next[decode_pkg::CAUSE_MMODE_ECALL] = dec_exc[decode_pkg::CAUSE_MMODE_ECALL];
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      pc_r     <= decode_pkg::PC_INIT;
      bubble_r <= 1'b1;
      exc_r    <= '0;
    end else if (flush) begin
      pc_r     <= flush_pc;
      bubble_r <= 1'b1;
      exc_r    <= '0;
    end else if (!ex_stall) begin
      if (id_stall) begin
        // pc holds, a bubble goes down the pipe
        bubble_r <= 1'b1;
        exc_r    <= '0;
      end else begin
        pc_r     <= fetch.pc;
        bubble_r <= fetch.bubble;
        exc_r    <= exc_next;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!ex_stall) begin
      instr_r <= fetch.instr;
    end
  end

  assign id.pc        = pc_r;
  assign id.instr     = instr_r;
  assign id.exception = exc_r;

endmodule

// ==== decode_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Shared definitions for the RV32I instruction decode stage.
// Holds widths, opcode and instruction encodings, exception cause
// indexes, privilege codes, the port structs and the opcode class rules.
// Modules refer to everything here by decode_pkg:: scoped names.
////////////////////////////////////////////////////////////////////////////

package decode_pkg;

  localparam int XLEN  = 32;
  localparam int ILEN  = 32;
  localparam int EXC_W = 16;
  localparam int REG_W = 5;

  localparam logic [XLEN-1:0] PC_INIT = 32'h0000_0200;

  // Major opcodes, instruction bits 6:2
  localparam logic [4:0] OPC_LOAD     = 5'b00000;
  localparam logic [4:0] OPC_MISC_MEM = 5'b00011;
  localparam logic [4:0] OPC_OP_IMM   = 5'b00100;
  localparam logic [4:0] OPC_AUIPC    = 5'b00101;
  localparam logic [4:0] OPC_STORE    = 5'b01000;
  localparam logic [4:0] OPC_OP       = 5'b01100;
  localparam logic [4:0] OPC_LUI      = 5'b01101;
  localparam logic [4:0] OPC_BRANCH   = 5'b11000;
  localparam logic [4:0] OPC_JALR     = 5'b11001;
  localparam logic [4:0] OPC_JAL      = 5'b11011;
  localparam logic [4:0] OPC_SYSTEM   = 5'b11100;

  // Fixed system encodings
  localparam logic [ILEN-1:0] ECALL  = 32'h0000_0073;
  localparam logic [ILEN-1:0] EBREAK = 32'h0010_0073;
  localparam logic [ILEN-1:0] MRET   = 32'h3020_0073;

  // Exception cause bit positions
  localparam int CAUSE_ILLEGAL_INSTRUCTION = 2;
  localparam int CAUSE_BREAKPOINT          = 3;
  localparam int CAUSE_UMODE_ECALL         = 8;
  localparam int CAUSE_SMODE_ECALL         = 9;
  localparam int CAUSE_MMODE_ECALL         = 11;

  localparam logic [1:0] PRV_U = 2'd0;
  localparam logic [1:0] PRV_S = 2'd1;
  localparam logic [1:0] PRV_M = 2'd3;

  // Implemented privilege modes besides machine mode
  localparam logic HAS_USER  = 1'b1;
  localparam logic HAS_SUPER = 1'b1;

  typedef struct packed {
    logic [XLEN-1:0]  pc;
    logic [ILEN-1:0]  instr;
    logic             bubble;
    logic [EXC_W-1:0] exception;
  } fetch_t;

  // Downstream stage as seen from decode
  typedef struct packed {
    logic [ILEN-1:0] instr;
    logic            bubble;
    logic            exc_pending;
  } stage_t;

  typedef struct packed {
    logic [XLEN-1:0]  pc;
    logic [ILEN-1:0]  instr;
    logic [EXC_W-1:0] exception;
  } decode_t;

  typedef struct packed {
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
  } operand_t;

  typedef struct packed {
    logic use_rf_a;
    logic use_rf_b;
    logic byp_ex_a;
    logic byp_ex_b;
    logic byp_mem_a;
    logic byp_mem_b;
    logic byp_wb_a;
    logic byp_wb_b;
  } bypass_t;

  ////////////////////////////////////////////////////////////////////////////
  // Opcode classes
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic reads_rs1(input logic [4:0] opc);
    return opc inside {OPC_OP_IMM, OPC_OP, OPC_BRANCH, OPC_JALR,
                       OPC_LOAD, OPC_STORE, OPC_SYSTEM};
  endfunction

  function automatic logic reads_rs2(input logic [4:0] opc);
    return opc inside {OPC_OP, OPC_BRANCH, OPC_STORE};
  endfunction

  function automatic logic writes_rd(input logic [4:0] opc);
    return opc inside {OPC_LOAD, OPC_OP_IMM, OPC_AUIPC, OPC_OP, OPC_LUI,
                       OPC_JALR, OPC_JAL, OPC_SYSTEM};
  endfunction

endpackage

// ==== decode_stage.sv ====
////////////////////////////////////////////////////////////////////////////
// Instruction decode stage of the five-stage RV32I pipeline.
// Takes the fetched item, produces the decode register, operands,
// bypass selects and register file addresses, and raises id_stall on a
// load-use hazard. id_bubble marks the decode slot as empty.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module decode_stage (
  input  logic                            clk,
  input  logic                            rstn,
  input  decode_pkg::fetch_t              fetch,
  input  decode_pkg::stage_t              ex_stage,
  input  decode_pkg::stage_t              mem_stage,
  input  decode_pkg::stage_t              wb_stage,
  input  logic [decode_pkg::XLEN-1:0]     wb_r,
  input  logic                            ex_stall,
  input  logic                            flush,
  input  logic [decode_pkg::XLEN-1:0]     flush_pc,
  input  logic [1:0]                      st_prv,
  output decode_pkg::decode_t             id,
  output logic                            id_bubble,
  output logic                            id_stall,
  output logic [decode_pkg::REG_W-1:0]    src1,
  output logic [decode_pkg::REG_W-1:0]    src2,
  output decode_pkg::operand_t            ops,
  output decode_pkg::bypass_t             byp
);

  logic [decode_pkg::EXC_W-1:0] dec_exc;
  logic                         bubble_r;

  // Slot is empty on a stall, a flush or any exception further down
  assign id_bubble = ex_stall | flush | bubble_r | ex_stage.exc_pending |
                     mem_stage.exc_pending | wb_stage.exc_pending;

  illegal_checker illegal_checker_inst (
    .instr   (fetch.instr),
    .bubble  (fetch.bubble),
    .st_prv  (st_prv),
    .dec_exc (dec_exc)
  );

  decode_pipe_reg decode_pipe_reg_inst (
    .clk      (clk),
    .rstn     (rstn),
    .fetch    (fetch),
    .dec_exc  (dec_exc),
    .ex_stall (ex_stall),
    .id_stall (id_stall),
    .flush    (flush),
    .flush_pc (flush_pc),
    .id       (id),
    .bubble_r (bubble_r)
  );

  operand_decoder operand_decoder_inst (
    .clk      (clk),
    .rstn     (rstn),
    .fetch    (fetch),
    .id_instr (id.instr),
    .wb_r     (wb_r),
    .ex_stall (ex_stall),
    .src1     (src1),
    .src2     (src2),
    .ops      (ops)
  );

  hazard_unit hazard_unit_inst (
    .clk          (clk),
    .rstn         (rstn),
    .fetch_instr  (fetch.instr),
    .fetch_bubble (fetch.bubble),
    .id_instr     (id.instr),
    .id_bubble    (id_bubble),
    .ex_stage     (ex_stage),
    .mem_stage    (mem_stage),
    .wb_stage     (wb_stage),
    .ex_stall     (ex_stall),
    .flush        (flush),
    .byp          (byp),
    .id_stall     (id_stall)
  );

endmodule

// ==== decode_stage_assertions.sv ====
////////////////////////////////////////////////////////////////////////////
// Concurrent checks on the flush and stall behavior of the decode stage.
// Bound into decode_stage from the testbench file set.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module decode_stage_assertions (
  input logic                        clk,
  input logic                        rstn,
  input logic                        flush,
  input logic                        ex_stall,
  input logic                        id_stall,
  input logic                        id_bubble,
  input logic [decode_pkg::XLEN-1:0] id_pc
);

  // A flush never stalls fetch
  flush_no_stall: assert property (@(posedge clk) disable iff (!rstn)
    flush |-> !id_stall)
    else $error("flush with id_stall high");

  flush_bubble: assert property (@(posedge clk) disable iff (!rstn)
    flush |=> id_bubble)
    else $error("no bubble in decode after flush");

  // Frozen pipe keeps the decode pc, flush takes priority
  stall_holds_pc: assert property (@(posedge clk) disable iff (!rstn)
    (ex_stall && !flush) |=> $stable(id_pc))
    else $error("decode pc moved under ex_stall");

endmodule

bind decode_stage decode_stage_assertions decode_stage_assertions_inst (
  .clk       (clk),
  .rstn      (rstn),
  .flush     (flush),
  .ex_stall  (ex_stall),
  .id_stall  (id_stall),
  .id_bubble (id_bubble),
  .id_pc     (id.pc)
);

// ==== hazard_unit.sv ====
////////////////////////////////////////////////////////////////////////////
// Data hazard handling for the fetched instruction.
// Registers the EX, MEM and WB bypass selects and the use-register-file
// flags, and raises id_stall when a source waits on a load ahead.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module hazard_unit (
  input  logic                         clk,
  input  logic                         rstn,
  input  logic [decode_pkg::ILEN-1:0]  fetch_instr,
  input  logic                         fetch_bubble,
  input  logic [decode_pkg::ILEN-1:0]  id_instr,
  input  logic                         id_bubble,
  input  decode_pkg::stage_t           ex_stage,
  input  decode_pkg::stage_t           mem_stage,
  input  decode_pkg::stage_t           wb_stage,
  input  logic                         ex_stall,
  input  logic                         flush,
  output decode_pkg::bypass_t          byp,
  output logic                         id_stall
);

  logic [4:0]                   opc;
  logic [decode_pkg::REG_W-1:0] rs1;
  logic [decode_pkg::REG_W-1:0] rs2;
  logic                         use_a;
  logic                         use_b;
  logic                         decoded;
  decode_pkg::bypass_t          byp_next;

  // Source matches a live writer further down and x0 never matches
  function automatic logic hit(input logic [decode_pkg::REG_W-1:0] src,
                               input logic [decode_pkg::ILEN-1:0]  instr,
                               input logic                         bubble);
    return (src == instr[11:7]) && (|instr[11:7]) &&
           decode_pkg::writes_rd(instr[6:2]) && !bubble;
  endfunction

  // Load result not yet available to a used source
  function automatic logic load_dep(input logic [decode_pkg::REG_W-1:0] rd);
    return (use_a && rs1 == rd) || (use_b && rs2 == rd);
  endfunction

  assign opc     = fetch_instr[6:2];
  assign rs1     = fetch_instr[19:15];
  assign rs2     = fetch_instr[24:20];
  assign use_a   = decode_pkg::reads_rs1(opc);
  assign use_b   = decode_pkg::reads_rs2(opc);
  assign decoded = use_a || opc == decode_pkg::OPC_LUI || opc == decode_pkg::OPC_AUIPC;

  always_comb begin
    byp_next.byp_ex_a  = use_a && hit(rs1, id_instr, id_bubble);
    byp_next.byp_ex_b  = use_b && hit(rs2, id_instr, id_bubble);
    byp_next.byp_mem_a = use_a && hit(rs1, ex_stage.instr, ex_stage.bubble);
    byp_next.byp_mem_b = use_b && hit(rs2, ex_stage.instr, ex_stage.bubble);
    byp_next.byp_wb_a  = use_a && hit(rs1, mem_stage.instr, mem_stage.bubble);
    byp_next.byp_wb_b  = use_b && hit(rs2, mem_stage.instr, mem_stage.bubble);
    // wb_r already carries the writeback result, so skip the file
    byp_next.use_rf_a  = !decoded || (use_a && !hit(rs1, wb_stage.instr, wb_stage.bubble));
    byp_next.use_rf_b  = !decoded || (use_b && !hit(rs2, wb_stage.instr, wb_stage.bubble));
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      byp <= '0;
    end else if (!ex_stall) begin
      byp <= byp_next;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Load-use stall
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    if (flush) begin
      id_stall = 1'b0;
    end else if (ex_stall) begin
      // Keep fetch holding anything real
      id_stall = !fetch_bubble;
    end else if (id_instr[6:2] == decode_pkg::OPC_LOAD && !id_bubble &&
                 load_dep(id_instr[11:7])) begin
      id_stall = 1'b1;
    end else if (ex_stage.instr[6:2] == decode_pkg::OPC_LOAD && !ex_stage.bubble &&
                 load_dep(ex_stage.instr[11:7])) begin
      id_stall = 1'b1;
    end else begin
      id_stall = 1'b0;
    end
  end

endmodule

// ==== illegal_checker.sv ====
////////////////////////////////////////////////////////////////////////////
// Legality check of the fetched instruction against RV32I plus FENCE,
// FENCE.I, ECALL, EBREAK and MRET. Drives the five decode cause bits,
// all other bits of dec_exc stay zero. Purely combinational.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module illegal_checker (
  input  logic [decode_pkg::ILEN-1:0]  instr,
  input  logic                         bubble,
  input  logic [1:0]                   st_prv,
  output logic [decode_pkg::EXC_W-1:0] dec_exc
);

  logic [4:0] opc;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       is_ecall;
  logic       is_ebreak;
  logic       illegal;

  assign opc       = instr[6:2];
  assign funct3    = instr[14:12];
  assign funct7    = instr[31:25];
  assign is_ecall  = instr == decode_pkg::ECALL;
  assign is_ebreak = instr == decode_pkg::EBREAK;

  always_comb begin
    case (opc)
      decode_pkg::OPC_LUI,
      decode_pkg::OPC_AUIPC,
      decode_pkg::OPC_JAL:      illegal = 1'b0;
      decode_pkg::OPC_JALR:     illegal = funct3 != 3'd0;
      decode_pkg::OPC_BRANCH:   illegal = funct3 inside {3'd2, 3'd3};
      // LB LH LW LBU LHU
      decode_pkg::OPC_LOAD:     illegal = funct3 inside {3'd3, 3'd6, 3'd7};
      decode_pkg::OPC_STORE:    illegal = funct3 > 3'd2;
      decode_pkg::OPC_OP_IMM: begin
        case (funct3)
          3'd1:    illegal = funct7 != 7'h00;
          3'd5:    illegal = funct7 != 7'h00 && funct7 != 7'h20;
          default: illegal = 1'b0;
        endcase
      end
      decode_pkg::OPC_OP: begin
        if (funct7 == 7'h00) begin
          illegal = 1'b0;
        end else begin
          // Only SUB and SRA use the alternate funct7
          illegal = !(funct7 == 7'h20 && (funct3 == 3'd0 || funct3 == 3'd5));
        end
      end
      // FENCE and FENCE.I
      decode_pkg::OPC_MISC_MEM: illegal = funct3 > 3'd1;
      decode_pkg::OPC_SYSTEM: begin
        // No CSR access, URET or SRET in this core
        illegal = !(is_ecall || is_ebreak ||
                    (instr == decode_pkg::MRET && st_prv == decode_pkg::PRV_M));
      end
      default:                  illegal = 1'b1;
    endcase
  end

  always_comb begin
    dec_exc = '0;
    dec_exc[decode_pkg::CAUSE_ILLEGAL_INSTRUCTION] = !bubble && illegal;
    dec_exc[decode_pkg::CAUSE_BREAKPOINT]          = !bubble && is_ebreak;
    dec_exc[decode_pkg::CAUSE_UMODE_ECALL] = !bubble && is_ecall &&
      st_prv == decode_pkg::PRV_U && decode_pkg::HAS_USER;
    dec_exc[decode_pkg::CAUSE_SMODE_ECALL] = !bubble && is_ecall &&
      st_prv == decode_pkg::PRV_S && decode_pkg::HAS_SUPER;
    dec_exc[decode_pkg::CAUSE_MMODE_ECALL] = !bubble && is_ecall &&
      st_prv == decode_pkg::PRV_M;
  end

endmodule

// ==== operand_decoder.sv ====
////////////////////////////////////////////////////////////////////////////
// Operand formation for the fetched instruction.
// Drives the register file source addresses and registers op_a and
// op_b from the I and U immediates, the pc or the writeback result.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module operand_decoder (
  input  logic                          clk,
  input  logic                          rstn,
  input  decode_pkg::fetch_t            fetch,
  input  logic [decode_pkg::ILEN-1:0]   id_instr,
  input  logic [decode_pkg::XLEN-1:0]   wb_r,
  input  logic                          ex_stall,
  output logic [decode_pkg::REG_W-1:0]  src1,
  output logic [decode_pkg::REG_W-1:0]  src2,
  output decode_pkg::operand_t          ops
);

  logic [4:0]                  opc;
  logic [decode_pkg::XLEN-1:0] imm_i;
  logic [decode_pkg::XLEN-1:0] imm_u;
  logic [decode_pkg::XLEN-1:0] rs1_zext;

  assign opc = fetch.instr[6:2];

  // Register file reads follow decode while the pipe is frozen
  assign src1 = ex_stall ? id_instr[19:15] : fetch.instr[19:15];
  assign src2 = ex_stall ? id_instr[24:20] : fetch.instr[24:20];

  assign imm_i    = {{(decode_pkg::XLEN-12){fetch.instr[31]}}, fetch.instr[31:20]};
  assign imm_u    = {fetch.instr[31:12], 12'b0};
  // Immediate of the CSR forms
  assign rs1_zext = {{(decode_pkg::XLEN-5){1'b0}}, fetch.instr[19:15]};

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      ops <= '0;
    end else if (!ex_stall) begin
      case (opc)
        decode_pkg::OPC_OP_IMM,
        decode_pkg::OPC_LOAD,
        decode_pkg::OPC_JALR: begin
          ops.op_a <= wb_r;
          ops.op_b <= imm_i;
        end
        decode_pkg::OPC_AUIPC: begin
          ops.op_a <= fetch.pc;
          ops.op_b <= imm_u;
        end
        decode_pkg::OPC_LUI: begin
          ops.op_a <= '0;
          ops.op_b <= imm_u;
        end
        decode_pkg::OPC_OP,
        decode_pkg::OPC_BRANCH,
        decode_pkg::OPC_STORE: begin
          ops.op_a <= wb_r;
          ops.op_b <= wb_r;
        end
        decode_pkg::OPC_SYSTEM: begin
          ops.op_a <= wb_r;
          ops.op_b <= rs1_zext;
        end
        default: begin
          // Other opcodes leave the operands as they are
          ops <= ops;
        end
      endcase
    end
  end

endmodule

// ==== project.f ====
decode_pkg.sv
illegal_checker.sv
decode_pipe_reg.sv
operand_decoder.sv
hazard_unit.sv
decode_stage.sv
decode_stage_assertions.sv
tb_decode_stage.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the decode stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_decode_stage -f project.f -o tb_sim

./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Test FAILED" sim.log; then
  exit 1
fi
grep -q "Test OK" sim.log

// ==== tb_decode_stage.sv ====
////////////////////////////////////////////////////////////////////////////
// Testbench for the decode stage. Drives random RV32I traffic through
// reset, operands, legality, bypass, load-use stall and flush, predicts
// every output with a reference model and compares at the falling edge.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_decode_stage;

  logic                        clk;
  logic                        rstn;
  decode_pkg::fetch_t          fetch;
  decode_pkg::stage_t          ex_stage, mem_stage, wb_stage;
  logic [decode_pkg::XLEN-1:0] wb_r, flush_pc;
  logic                        ex_stall, flush;
  logic [1:0]                  st_prv;
  decode_pkg::decode_t         id;
  logic                        id_bubble, id_stall;
  logic [decode_pkg::REG_W-1:0] src1, src2;
  decode_pkg::operand_t        ops;
  decode_pkg::bypass_t         byp;

  // Reference model state for the current and the next cycle
  logic [31:0] m_pc, m_instr, n_pc, n_instr;
  logic [15:0] m_exc, n_exc;
  logic        m_bub, n_bub;
  decode_pkg::operand_t m_ops, n_ops;
  decode_pkg::bypass_t  m_byp, n_byp;
  logic        exp_stall, exp_idb, chk, rst_drv;
  logic [4:0]  exp_src1, exp_src2;
  int          errors, checks, cnt;
  integer      seed;
  logic [4:0]  opc_list [7];
  decode_pkg::fetch_t f;
  decode_pkg::stage_t s_idle, s_ex, s_mem, s_wb;

  decode_stage decode_stage_inst (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic uses_a(input logic [4:0] o);
    return o == decode_pkg::OPC_OP_IMM || o == decode_pkg::OPC_OP || o == decode_pkg::OPC_BRANCH ||
           o == decode_pkg::OPC_JALR || o == decode_pkg::OPC_LOAD || o == decode_pkg::OPC_STORE ||
           o == decode_pkg::OPC_SYSTEM;
  endfunction

  function automatic logic uses_b(input logic [4:0] o);
    return o == decode_pkg::OPC_OP || o == decode_pkg::OPC_BRANCH || o == decode_pkg::OPC_STORE;
  endfunction

  function automatic logic has_rd(input logic [4:0] o);
    return !(o == decode_pkg::OPC_STORE || o == decode_pkg::OPC_BRANCH ||
             o == decode_pkg::OPC_MISC_MEM) && (uses_a(o) || o == decode_pkg::OPC_LUI ||
             o == decode_pkg::OPC_AUIPC || o == decode_pkg::OPC_JAL);
  endfunction

  function automatic logic writer(input logic [4:0] s, input logic [31:0] i, input logic b);
    return s == i[11:7] && i[11:7] != 5'd0 && has_rd(i[6:2]) && !b;
  endfunction

  function automatic logic legal(input logic [31:0] i, input logic [1:0] prv);
    logic [2:0] f3;
    logic [6:0] f7;
    f3 = i[14:12];
    f7 = i[31:25];
    case (i[6:2])
      decode_pkg::OPC_LUI, decode_pkg::OPC_AUIPC, decode_pkg::OPC_JAL: return 1'b1;
      decode_pkg::OPC_JALR:     return f3 == 3'd0;
      decode_pkg::OPC_BRANCH:   return f3 != 3'd2 && f3 != 3'd3;
      decode_pkg::OPC_LOAD:     return f3 <= 3'd2 || f3 == 3'd4 || f3 == 3'd5;
      decode_pkg::OPC_STORE:    return f3 <= 3'd2;
      decode_pkg::OPC_OP_IMM:   return f3 == 3'd1 ? f7 == 7'h00 :
                                       f3 == 3'd5 ? (f7 == 7'h00 || f7 == 7'h20) : 1'b1;
      decode_pkg::OPC_OP:       return f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
      decode_pkg::OPC_MISC_MEM: return f3 <= 3'd1;
      decode_pkg::OPC_SYSTEM:   return i == decode_pkg::ECALL || i == decode_pkg::EBREAK ||
                                       (i == decode_pkg::MRET && prv == decode_pkg::PRV_M);
      default:                  return 1'b0;
    endcase
  endfunction

  // Reference model stepped once from the applied inputs
  function automatic void predict(input logic rst, input logic [31:0] wr);
    logic [4:0]  opc, rs1, rs2;
    logic        ua, ub, dec, ecall;
    logic [31:0] imm_i, imm_u;
    opc = fetch.instr[6:2];
    rs1 = fetch.instr[19:15];
    rs2 = fetch.instr[24:20];
    ua = uses_a(opc);
    ub = uses_b(opc);
    dec = ua || opc == decode_pkg::OPC_LUI || opc == decode_pkg::OPC_AUIPC;
    ecall = fetch.instr == decode_pkg::ECALL && !fetch.bubble;
    imm_i = {{20{fetch.instr[31]}}, fetch.instr[31:20]};
    imm_u = {fetch.instr[31:12], 12'b0};
    exp_idb = ex_stall | flush | m_bub | ex_stage.exc_pending | mem_stage.exc_pending |
              wb_stage.exc_pending;
    if (flush) begin
      exp_stall = 1'b0;
    end else if (ex_stall) begin
      exp_stall = !fetch.bubble;
    end else begin
      exp_stall = (m_instr[6:2] == decode_pkg::OPC_LOAD && !exp_idb &&
                   ((ua && rs1 == m_instr[11:7]) || (ub && rs2 == m_instr[11:7]))) ||
                  (ex_stage.instr[6:2] == decode_pkg::OPC_LOAD && !ex_stage.bubble &&
                   ((ua && rs1 == ex_stage.instr[11:7]) ||
                    (ub && rs2 == ex_stage.instr[11:7])));
    end
    exp_src1 = ex_stall ? m_instr[19:15] : rs1;
    exp_src2 = ex_stall ? m_instr[24:20] : rs2;
    n_instr = ex_stall ? m_instr : fetch.instr;
    {n_pc, n_bub, n_exc, n_ops, n_byp} = {m_pc, m_bub, m_exc, m_ops, m_byp};
    if (rst) begin
      {n_pc, n_bub, n_exc, n_ops, n_byp} = {decode_pkg::PC_INIT, 1'b1, 16'h0, 64'h0, 8'h0};
    end else begin
      if (flush) begin
        {n_pc, n_bub, n_exc} = {flush_pc, 1'b1, 16'h0};
      end else if (!ex_stall && exp_stall) begin
        {n_bub, n_exc} = {1'b1, 16'h0};
      end else if (!ex_stall) begin
        {n_pc, n_bub, n_exc} = {fetch.pc, fetch.bubble, fetch.exception};
        n_exc[2] = !fetch.bubble && !legal(fetch.instr, st_prv);
        n_exc[3] = !fetch.bubble && fetch.instr == decode_pkg::EBREAK;
        n_exc[8] = ecall && st_prv == decode_pkg::PRV_U;
        n_exc[9] = ecall && st_prv == decode_pkg::PRV_S;
        n_exc[11] = ecall && st_prv == decode_pkg::PRV_M;
      end
      if (!ex_stall) begin
        case (opc)
          decode_pkg::OPC_OP_IMM, decode_pkg::OPC_LOAD, decode_pkg::OPC_JALR: n_ops = {wr, imm_i};
          decode_pkg::OPC_AUIPC: n_ops = {fetch.pc, imm_u};
          decode_pkg::OPC_LUI: n_ops = {32'h0, imm_u};
          decode_pkg::OPC_OP, decode_pkg::OPC_BRANCH, decode_pkg::OPC_STORE: n_ops = {wr, wr};
          decode_pkg::OPC_SYSTEM: n_ops = {wr, 27'h0, rs1};
          default: n_ops = m_ops;
        endcase
        n_byp.byp_ex_a  = ua && writer(rs1, m_instr, exp_idb);
        n_byp.byp_ex_b  = ub && writer(rs2, m_instr, exp_idb);
        n_byp.byp_mem_a = ua && writer(rs1, ex_stage.instr, ex_stage.bubble);
        n_byp.byp_mem_b = ub && writer(rs2, ex_stage.instr, ex_stage.bubble);
        n_byp.byp_wb_a  = ua && writer(rs1, mem_stage.instr, mem_stage.bubble);
        n_byp.byp_wb_b  = ub && writer(rs2, mem_stage.instr, mem_stage.bubble);
        n_byp.use_rf_a  = !dec || (ua && !writer(rs1, wb_stage.instr, wb_stage.bubble));
        n_byp.use_rf_b  = !dec || (ub && !writer(rs2, wb_stage.instr, wb_stage.bubble));
      end
    end
  endfunction

  // One cycle of stimulus while the model advances with the DUT
  task automatic apply(input decode_pkg::fetch_t fi, input logic exs, input logic fl,
                       input logic [1:0] prv);
    logic [31:0] wr, fpc;
    @(posedge clk);
    {m_pc, m_instr, m_bub, m_exc, m_ops, m_byp} = {n_pc, n_instr, n_bub, n_exc, n_ops, n_byp};
    chk = 1'b1;
    wr = $random(seed);
    fpc = $random(seed);
    rstn <= rst_drv;
    fetch <= fi;
    {ex_stage, mem_stage, wb_stage} <= {s_ex, s_mem, s_wb};
    wb_r <= wr;
    ex_stall <= exs;
    flush <= fl;
    flush_pc <= fpc;
    st_prv <= prv;
    #1;
    predict(!rst_drv, wr);
  endtask

  task automatic check(input string name, input logic [95:0] e, input logic [95:0] g);
    checks++;
    if (g !== e) begin
      errors++;
      $display("FAILED t=%0t %s expected %h got %h", $time, name, e, g);
    end
  endtask

  always @(negedge clk) begin
    if (chk) begin
      check("id_stall", exp_stall, id_stall);
      check("id_bubble", exp_idb, id_bubble);
      check("id.pc", m_pc, id.pc);
      check("id.instr", m_instr, id.instr);
      check("id.exception", m_exc, id.exception);
      check("ops", m_ops, ops);
      check("byp", m_byp, byp);
      check("src1", exp_src1, src1);
      check("src2", exp_src2, src2);
    end
  end

  task automatic random_fetch(input logic [4:0] opc);
    logic [31:0] word;
    f.pc = $random(seed);
    word = $random(seed);
    f.instr = {word[31:7], opc, 2'b11};
    f.bubble = 1'b0;
    f.exception = 16'h0;
  endtask

  task automatic random_stage(output decode_pkg::stage_t s, input logic [4:0] rd_pick);
    s.instr = $random(seed);
    s.instr[11:7] = ($random(seed) & 3) == 0 ? 5'd0 : rd_pick;
    s.bubble = ($random(seed) & 3) == 0;
    s.exc_pending = ($random(seed) & 7) == 0;
  endtask

  initial begin
    seed = 32'h2aa0_bfa2;
    opc_list = '{decode_pkg::OPC_OP_IMM, decode_pkg::OPC_LUI, decode_pkg::OPC_AUIPC,
                 decode_pkg::OPC_LOAD, decode_pkg::OPC_STORE, decode_pkg::OPC_BRANCH,
                 decode_pkg::OPC_OP};
    s_idle = '{instr: 32'h0, bubble: 1'b1, exc_pending: 1'b0};
    {s_ex, s_mem, s_wb} = {s_idle, s_idle, s_idle};
    {rstn, rst_drv, ex_stall, flush, chk, wb_r, flush_pc, st_prv} = '0;
    fetch = '{pc: 32'h0, instr: 32'h0, bubble: 1'b1, exception: 16'h0};
    {n_pc, n_instr, n_bub, n_exc, n_ops, n_byp} = {decode_pkg::PC_INIT, 32'h0, 1'b1, 16'h0,
                                                   64'h0, 8'h0};
    {errors, checks} = '0;
    // Reset with fetch empty
    repeat (8) apply(fetch, 1'b0, 1'b0, decode_pkg::PRV_M);
    rst_drv = 1'b1;
    apply(fetch, 1'b0, 1'b0, decode_pkg::PRV_M);
    // Operands
    repeat (40) begin
      random_fetch(opc_list[$unsigned($random(seed)) % 7]);
      apply(f, 1'b0, 1'b0, decode_pkg::PRV_M);
    end
    // Legality and exception causes
    repeat (80) begin
      random_fetch(5'($random(seed)));
      f.exception = 16'($random(seed));
      case ($unsigned($random(seed)) % 5)
        0: f.instr = decode_pkg::ECALL;
        1: f.instr = decode_pkg::EBREAK;
        2: f.instr = decode_pkg::MRET;
        3: f.instr = {f.instr[31:15], 3'($random(seed)) | 3'd1, f.instr[11:7], 7'h73};
        default: f.instr[1:0] = 2'b11;
      endcase
      apply(f, 1'b0, 1'b0, 2'($random(seed)));
    end
    // Bypass selection against writers further down
    repeat (60) begin
      random_fetch(opc_list[$unsigned($random(seed)) % 7]);
      random_stage(s_ex, $random(seed) & 1 ? f.instr[19:15] : f.instr[24:20]);
      random_stage(s_mem, $random(seed) & 1 ? f.instr[19:15] : f.instr[24:20]);
      random_stage(s_wb, $random(seed) & 1 ? f.instr[19:15] : f.instr[24:20]);
      apply(f, 1'b0, 1'b0, decode_pkg::PRV_M);
    end
    {s_ex, s_mem, s_wb} = {s_idle, s_idle, s_idle};
    // Load followed by a dependent instruction
    for (int k = 0; k < 4; k++) begin
      random_fetch(decode_pkg::OPC_LOAD);
      f.instr[11:7] = k[0] ? 5'd6 : 5'd5;
      apply(f, 1'b0, 1'b0, decode_pkg::PRV_M);
      random_fetch(decode_pkg::OPC_OP);
      f.instr[19:15] = 5'd5;
      f.instr[24:20] = 5'd5;
      if (k[0]) begin
        // Odd passes depend on a load in EX behind an unrelated load
        s_ex.instr  = {20'h0, 5'd5, decode_pkg::OPC_LOAD, 2'b11};
        s_ex.bubble = 1'b0;
      end
      apply(f, 1'b0, 1'b0, decode_pkg::PRV_M);
      s_ex = s_idle;
      cnt = 0;
      while (exp_stall && cnt < 10) begin
        apply(f, 1'b0, 1'b0, decode_pkg::PRV_M);
        cnt++;
      end
      if (exp_stall) begin
        errors++;
        $display("Timeout: load-use stall did not clear within 10 cycles");
      end
      repeat (3) begin
        f.bubble = 1'($random(seed));
        apply(f, 1'b1, 1'b0, decode_pkg::PRV_M);
      end
    end
    // Flush pulses
    repeat (6) begin
      random_fetch(opc_list[$unsigned($random(seed)) % 7]);
      apply(f, 1'b0, 1'b1, decode_pkg::PRV_M);
      apply(f, 1'b0, 1'b0, decode_pkg::PRV_M);
    end
    apply(fetch, 1'b0, 1'b0, decode_pkg::PRV_M);
    @(negedge clk);
    @(posedge clk);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule
